/* include/roc_defs.svh */
// ----------------------------------------------------------
// Size settings of the read-only cache
// Line count must be a power of two; lines are one word wide
// Widths below 32 bits are not supported
// ----------------------------------------------------------

`ifndef ROC_DEFS_SVH
`define ROC_DEFS_SVH

// Byte address and data word widths
`define ROC_ADDR_W 32
`define ROC_DATA_W 32

// Direct-mapped lines and cacheable regions
`define ROC_LINE_COUNT 16
`define ROC_NR_RULES 2

`endif

/* verilog/roc_pkg.sv */
// ----------------------------------------------------------
// Types shared by the read-only cache blocks
// Word offset is fixed at 2 bits (32-bit words)
// ----------------------------------------------------------

`include "roc_defs.svh"

package roc_pkg;

  localparam int unsigned OFFSET_W = 2;
  localparam int unsigned INDEX_W  = $clog2(`ROC_LINE_COUNT);
  localparam int unsigned TAG_W    = `ROC_ADDR_W - INDEX_W - OFFSET_W;

  typedef logic [`ROC_ADDR_W-1:0] addr_t;
  typedef logic [`ROC_DATA_W-1:0] data_t;
  typedef logic [INDEX_W-1:0]     index_t;
  typedef logic [TAG_W-1:0]       tag_t;

  // Lookup FSM
  typedef enum logic [1:0] {LK_IDLE, LK_RESPOND, LK_REFILL} lookup_state_e;

  // Which bus currently owns the memory port
  typedef enum logic [1:0] {OWN_NONE, OWN_BYPASS, OWN_REFILL} arb_owner_e;

endpackage

/* verilog/roc_mem_if.sv */
// ----------------------------------------------------------
// Word-wide request/response bus
// Responses are single-cycle pulses and cannot be stalled
// ----------------------------------------------------------

`timescale 1ns/1ps

interface roc_mem_if;
  import roc_pkg::*;

  // Request channel
  logic  valid;
  logic  ready;
  addr_t addr;
  logic  write;
  data_t wdata;

  // Response channel
  logic  rsp_valid;
  data_t rsp_data;

  modport requester (
    output valid, addr, write, wdata,
    input  ready, rsp_valid, rsp_data
  );

  modport responder (
    input  valid, addr, write, wdata,
    output ready, rsp_valid, rsp_data
  );

endinterface

/* verilog/roc_region_route.sv */
// ----------------------------------------------------------
// Steers requests to the cache or the bypass bus
// One request in flight; regions are [start, end)
// Write responses return zero data
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "roc_defs.svh"

module roc_region_route (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                enable_i,
  input  roc_pkg::addr_t [`ROC_NR_RULES-1:0]  start_addr_i,
  input  roc_pkg::addr_t [`ROC_NR_RULES-1:0]  end_addr_i,
  input  logic                                req_valid_i,
  input  roc_pkg::addr_t                      req_addr_i,
  input  logic                                req_write_i,
  input  roc_pkg::data_t                      req_wdata_i,
  output logic                                req_ready_o,
  output logic                                rsp_valid_o,
  output roc_pkg::data_t                      rsp_data_o,
  input  logic                                rsp_ready_i,
  roc_mem_if.requester                        cache_bus,
  roc_mem_if.requester                        bypass_bus
);
  import roc_pkg::*;

  logic  busy_q, to_cache_q, fwd_q, write_q, hold_q;
  addr_t addr_q;
  data_t wdata_q, hold_data_q;
  logic  in_region, route_cache, sel_cache, accept;
  logic  fwd_valid, fwd_ready, sel_rsp_valid;
  data_t sel_rsp_data;

  // ----------------------------------------------------------
  // Region decode
  // ----------------------------------------------------------
  always_comb begin
    in_region = 1'b0;
    for (int i = 0; i < `ROC_NR_RULES; i++) begin
      if (req_addr_i >= start_addr_i[i] && req_addr_i < end_addr_i[i]) begin
        in_region = 1'b1;
      end
    end
  end

  // Only enabled reads inside a region are cacheable
  assign route_cache = enable_i && !req_write_i && in_region;
  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && !busy_q;
  assign sel_cache   = busy_q ? to_cache_q : route_cache;

  // Live request on the accepting cycle, stored copy while stalled
  assign fwd_valid        = accept || fwd_q;
  assign cache_bus.valid  = fwd_valid && sel_cache;
  assign bypass_bus.valid = fwd_valid && !sel_cache;
  assign cache_bus.addr   = fwd_q ? addr_q : req_addr_i;
  assign cache_bus.write  = fwd_q ? write_q : req_write_i;
  assign cache_bus.wdata  = fwd_q ? wdata_q : req_wdata_i;
  assign bypass_bus.addr  = cache_bus.addr;
  assign bypass_bus.write = cache_bus.write;
  assign bypass_bus.wdata = cache_bus.wdata;
  assign fwd_ready        = sel_cache ? cache_bus.ready : bypass_bus.ready;

  // ----------------------------------------------------------
  // Response return
  // ----------------------------------------------------------
  assign sel_rsp_valid = to_cache_q ? cache_bus.rsp_valid : bypass_bus.rsp_valid;
  assign sel_rsp_data  = to_cache_q ? cache_bus.rsp_data :
                         (write_q ? '0 : bypass_bus.rsp_data);

  assign rsp_valid_o = busy_q && (hold_q || sel_rsp_valid);
  assign rsp_data_o  = hold_q ? hold_data_q : sel_rsp_data;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      to_cache_q <= 1'b0;
      fwd_q      <= 1'b0;
      hold_q     <= 1'b0;
    end else begin
      if (accept) begin
        busy_q     <= 1'b1;
        to_cache_q <= route_cache;
        fwd_q      <= !fwd_ready;
      end else if (fwd_q && fwd_ready) begin
        fwd_q <= 1'b0;
      end
      // Park the response while the requester stalls
      if (busy_q && rsp_valid_o) begin
        if (rsp_ready_i) begin
          busy_q <= 1'b0;
          hold_q <= 1'b0;
        end else begin
          hold_q <= 1'b1;
        end
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= req_addr_i;
      write_q <= req_write_i;
      wdata_q <= req_wdata_i;
    end
    if (busy_q && sel_rsp_valid && !hold_q) begin
      hold_data_q <= sel_rsp_data;
    end
  end

endmodule

/* verilog/roc_lookup.sv */
// ----------------------------------------------------------
// Direct-mapped cache of single-word lines
// Read only: writes never reach this block
// Flush clears all valid bits, only while idle
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "roc_defs.svh"

module roc_lookup (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         flush_valid_i,
  output logic         flush_ready_o,
  roc_mem_if.responder cache_bus,
  roc_mem_if.requester refill_bus
);
  import roc_pkg::*;

  // Line storage
  data_t data_q [`ROC_LINE_COUNT];
  tag_t  tag_q  [`ROC_LINE_COUNT];
  logic [`ROC_LINE_COUNT-1:0] valid_q;

  lookup_state_e state_q;
  logic   sent_q;
  addr_t  addr_q;
  data_t  rsp_data_q;
  index_t req_index, idx_q;
  tag_t   req_tag, refill_tag;
  logic   accept, hit;

  // ----------------------------------------------------------
  // Hit check
  // ----------------------------------------------------------
  assign req_index = cache_bus.addr[OFFSET_W +: INDEX_W];
  assign req_tag   = cache_bus.addr[`ROC_ADDR_W-1 -: TAG_W];
  assign idx_q      = addr_q[OFFSET_W +: INDEX_W];
  assign refill_tag = addr_q[`ROC_ADDR_W-1 -: TAG_W];

  assign accept = cache_bus.valid && (state_q == LK_IDLE);
  // A flush on the same edge wins over a stale hit
  assign hit    = valid_q[req_index] && (tag_q[req_index] == req_tag) && !flush_valid_i;

  assign cache_bus.ready     = (state_q == LK_IDLE);
  assign flush_ready_o       = (state_q == LK_IDLE);
  assign cache_bus.rsp_valid = (state_q == LK_RESPOND);
  assign cache_bus.rsp_data  = rsp_data_q;

  // Refill is a single word read of the missing address
  assign refill_bus.valid = (state_q == LK_REFILL) && !sent_q;
  assign refill_bus.addr  = addr_q;
  assign refill_bus.write = 1'b0;
  assign refill_bus.wdata = '0;

  // ----------------------------------------------------------
  // FSM and valid bits
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= LK_IDLE;
      sent_q  <= 1'b0;
      valid_q <= '0;
    end else begin
      case (state_q)
        LK_IDLE: begin
          if (flush_valid_i) begin
            valid_q <= '0;
          end
          if (accept) begin
            state_q <= hit ? LK_RESPOND : LK_REFILL;
          end
        end
        LK_REFILL: begin
          if (refill_bus.valid && refill_bus.ready) begin
            sent_q <= 1'b1;
          end
          if (refill_bus.rsp_valid) begin
            valid_q[idx_q] <= 1'b1;
            sent_q         <= 1'b0;
            state_q        <= LK_RESPOND;
          end
        end
        LK_RESPOND: state_q <= LK_IDLE;
        default:    state_q <= LK_IDLE;
      endcase
    end
  end

  // Data, tags and the response word
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q     <= cache_bus.addr;
      rsp_data_q <= data_q[req_index];
    end
    if (state_q == LK_REFILL && refill_bus.rsp_valid) begin
      data_q[idx_q] <= refill_bus.rsp_data;
      tag_q[idx_q]  <= refill_tag;
      rsp_data_q    <= refill_bus.rsp_data;
    end
  end

endmodule

/* verilog/roc_mem_arbiter.sv */
// ----------------------------------------------------------
// Shares the memory port between bypass and refill
// Grant is held until the owner's response returns
// Refill wins when both request in the same cycle
// ----------------------------------------------------------

`timescale 1ns/1ps

module roc_mem_arbiter (
  input  logic           clk_i,
  input  logic           rst_n_i,
  roc_mem_if.responder   bypass_bus,
  roc_mem_if.responder   refill_bus,
  output logic           mem_req_valid_o,
  output roc_pkg::addr_t mem_req_addr_o,
  output logic           mem_req_write_o,
  output roc_pkg::data_t mem_req_wdata_o,
  input  logic           mem_req_ready_i,
  input  logic           mem_rsp_valid_i,
  input  roc_pkg::data_t mem_rsp_data_i
);
  import roc_pkg::*;

  arb_owner_e owner_q, pick, cur;

  // Fresh choice, only used while nobody owns the port
  always_comb begin
    if (refill_bus.valid) begin
      pick = OWN_REFILL;
    end else if (bypass_bus.valid) begin
      pick = OWN_BYPASS;
    end else begin
      pick = OWN_NONE;
    end
  end

  assign cur = (owner_q != OWN_NONE) ? owner_q : pick;

  // ----------------------------------------------------------
  // Request mux
  // ----------------------------------------------------------
  always_comb begin
    mem_req_valid_o = 1'b0;
    mem_req_addr_o  = bypass_bus.addr;
    mem_req_write_o = bypass_bus.write;
    mem_req_wdata_o = bypass_bus.wdata;
    case (cur)
      OWN_BYPASS: mem_req_valid_o = bypass_bus.valid;
      OWN_REFILL: begin
        mem_req_valid_o = refill_bus.valid;
        mem_req_addr_o  = refill_bus.addr;
        mem_req_write_o = refill_bus.write;
        mem_req_wdata_o = refill_bus.wdata;
      end
      default: mem_req_valid_o = 1'b0;
    endcase
  end

  assign bypass_bus.ready = mem_req_ready_i && (cur == OWN_BYPASS);
  assign refill_bus.ready = mem_req_ready_i && (cur == OWN_REFILL);

  // Response goes to the owner only
  assign bypass_bus.rsp_valid = mem_rsp_valid_i && (owner_q == OWN_BYPASS);
  assign refill_bus.rsp_valid = mem_rsp_valid_i && (owner_q == OWN_REFILL);
  assign bypass_bus.rsp_data  = mem_rsp_data_i;
  assign refill_bus.rsp_data  = mem_rsp_data_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      owner_q <= OWN_NONE;
    end else if (owner_q != OWN_NONE) begin
      if (mem_rsp_valid_i) begin
        owner_q <= OWN_NONE;
      end
    end else begin
      // Lock on first presentation so a stalled request stays put
      owner_q <= pick;
    end
  end

endmodule

/* verilog/read_only_cache.sv */
// ----------------------------------------------------------
// Read-only cache top level
// Only in-region reads with enable_i high are cached
// Writes do not update the cache; flush to see new data
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "roc_defs.svh"

module read_only_cache (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // Configuration
  input  logic                               enable_i,
  input  roc_pkg::addr_t [`ROC_NR_RULES-1:0] start_addr_i,
  input  roc_pkg::addr_t [`ROC_NR_RULES-1:0] end_addr_i,
  input  logic                               flush_valid_i,
  output logic                               flush_ready_o,
  // Requester side
  input  logic                               req_valid_i,
  input  roc_pkg::addr_t                     req_addr_i,
  input  logic                               req_write_i,
  input  roc_pkg::data_t                     req_wdata_i,
  output logic                               req_ready_o,
  output logic                               rsp_valid_o,
  output roc_pkg::data_t                     rsp_data_o,
  input  logic                               rsp_ready_i,
  // Memory side
  output logic                               mem_req_valid_o,
  output roc_pkg::addr_t                     mem_req_addr_o,
  output logic                               mem_req_write_o,
  output roc_pkg::data_t                     mem_req_wdata_o,
  input  logic                               mem_req_ready_i,
  input  logic                               mem_rsp_valid_i,
  input  roc_pkg::data_t                     mem_rsp_data_i
);

  roc_mem_if cache_bus ();
  roc_mem_if bypass_bus ();
  roc_mem_if refill_bus ();

  roc_region_route i_region_route (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .enable_i     ( enable_i     ),
    .start_addr_i ( start_addr_i ),
    .end_addr_i   ( end_addr_i   ),
    .req_valid_i  ( req_valid_i  ),
    .req_addr_i   ( req_addr_i   ),
    .req_write_i  ( req_write_i  ),
    .req_wdata_i  ( req_wdata_i  ),
    .req_ready_o  ( req_ready_o  ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_data_o   ( rsp_data_o   ),
    .rsp_ready_i  ( rsp_ready_i  ),
    .cache_bus    ( cache_bus    ),
    .bypass_bus   ( bypass_bus   )
  );

  roc_lookup i_lookup (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .flush_valid_i ( flush_valid_i ),
    .flush_ready_o ( flush_ready_o ),
    .cache_bus     ( cache_bus     ),
    .refill_bus    ( refill_bus    )
  );

  roc_mem_arbiter i_mem_arbiter (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .bypass_bus      ( bypass_bus      ),
    .refill_bus      ( refill_bus      ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_addr_o  ( mem_req_addr_o  ),
    .mem_req_write_o ( mem_req_write_o ),
    .mem_req_wdata_o ( mem_req_wdata_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .mem_rsp_data_i  ( mem_rsp_data_i  )
  );

endmodule

/* tb/tb_clock_gen.sv */
// ----------------------------------------------------------
// Clock and reset source for the testbench
// 40 ns period; reset low for the first 8 rising edges
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Synchronous release on a rising edge
  initial begin
    rst_n_o <= 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* tb/roc_checker.sv */
// ----------------------------------------------------------
// Response checker for the read-only cache
// Expects one request in flight; mode 1 hit, mode 2 memory
// ----------------------------------------------------------

`timescale 1ns/1ps

module roc_checker (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           req_valid_i,
  input  logic           req_ready_i,
  input  roc_pkg::addr_t req_addr_i,
  input  logic           req_write_i,
  input  roc_pkg::data_t req_wdata_i,
  input  logic           rsp_valid_i,
  input  logic           rsp_ready_i,
  input  roc_pkg::data_t rsp_data_i,
  input  logic           mem_req_valid_i,
  input  logic           mem_req_ready_i,
  input  roc_pkg::addr_t mem_req_addr_i,
  input  logic           mem_req_write_i,
  input  roc_pkg::data_t mem_req_wdata_i,
  input  logic           flush_valid_i,
  input  logic           flush_ready_i,
  input  int             test_id_i,
  input  roc_pkg::data_t exp_data_i,
  input  logic [1:0]     exp_mode_i,
  output int             tests_o,
  output int             errors_o
);
  import roc_pkg::*;

  localparam logic [1:0] MODE_HIT = 2'd1;
  localparam logic [1:0] MODE_MEM = 2'd2;

  int         cycle = 0;
  int         test_cnt = 0;
  int         err_cnt = 0;
  int         acc_cycle = 0;
  int         mem_seen = 0;
  int         cur_id = 0;
  int         test_errs = 0;
  logic       waiting_first = 1'b0;
  logic       cur_write = 1'b0;
  addr_t      cur_addr = '0;
  data_t      cur_wdata = '0;
  data_t      cur_exp = '0;
  logic [1:0] cur_mode = 2'd0;

  assign tests_o  = test_cnt;
  assign errors_o = err_cnt;

  always @(posedge clk_i) begin
    cycle++;
    if (rst_n_i) begin
      // Latch what this request should produce
      if (req_valid_i && req_ready_i) begin
        acc_cycle     = cycle;
        mem_seen      = 0;
        test_errs     = 0;
        waiting_first = 1'b1;
        cur_id        = test_id_i;
        cur_write     = req_write_i;
        cur_addr      = req_addr_i;
        cur_wdata     = req_wdata_i;
        cur_exp       = exp_data_i;
        cur_mode      = exp_mode_i;
      end
      // Bypass requests can reach memory on the accepting edge
      if (mem_req_valid_i && mem_req_ready_i) begin
        mem_seen++;
        if (mem_req_addr_i != cur_addr) begin
          $display("error mem_req_addr_o test %0d expected %h got %h",
                   cur_id, cur_addr, mem_req_addr_i);
          test_errs++;
        end
        if (mem_req_write_i !== cur_write) begin
          $display("error mem_req_write_o test %0d expected %h got %h",
                   cur_id, cur_write, mem_req_write_i);
          test_errs++;
        end
        if (cur_write && mem_req_wdata_i !== cur_wdata) begin
          $display("error mem_req_wdata_o test %0d expected %h got %h",
                   cur_id, cur_wdata, mem_req_wdata_i);
          test_errs++;
        end
      end
      if (rsp_valid_i && waiting_first) begin
        waiting_first = 1'b0;
        if (cur_mode == MODE_HIT && cycle - acc_cycle != 1) begin
          $display("test %0d: hit answered %0d cycles after acceptance instead of 1",
                   cur_id, cycle - acc_cycle);
          test_errs++;
        end
      end
      if (rsp_valid_i && rsp_ready_i) begin
        if (rsp_data_i !== cur_exp) begin
          $display("error rsp_data_o test %0d expected %h got %h",
                   cur_id, cur_exp, rsp_data_i);
          test_errs++;
        end
        if (cur_mode == MODE_HIT && mem_seen != 0) begin
          $display("test %0d: a cache hit sent a request to memory", cur_id);
          test_errs++;
        end
        if (cur_mode == MODE_MEM && mem_seen == 0) begin
          $display("test %0d: no request reached the memory port", cur_id);
          test_errs++;
        end
        $display("test %0d %s %h: %s", cur_id, cur_write ? "write" : "read",
                 cur_addr, (test_errs == 0) ? "pass" : "fail");
        err_cnt  += test_errs;
        test_cnt++;
      end
      if (flush_valid_i && flush_ready_i) begin
        $display("test %0d flush: pass", test_id_i);
        test_cnt++;
      end
    end
  end

endmodule

/* tb/roc_asserts.sv */
// ----------------------------------------------------------
// Handshake assertions bound into read_only_cache
// Inactive while rst_n_i is low
// ----------------------------------------------------------

`timescale 1ns/1ps

module roc_asserts (
  input logic           clk_i,
  input logic           rst_n_i,
  input logic           req_valid_i,
  input logic           req_ready_i,
  input logic           rsp_valid_i,
  input logic           rsp_ready_i,
  input roc_pkg::data_t rsp_data_i,
  input logic           mem_req_valid_i,
  input logic           mem_req_ready_i,
  input roc_pkg::addr_t mem_req_addr_i,
  input logic           mem_req_write_i,
  input roc_pkg::data_t mem_req_wdata_i
);

  // Response held while the requester stalls
  rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_data_i))
    else $error("response changed while rsp_ready_i was low");

  // Memory request held while memory stalls
  mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i &&
      $stable(mem_req_addr_i) && $stable(mem_req_write_i) && $stable(mem_req_wdata_i))
    else $error("memory request changed while mem_req_ready_i was low");

  // Ready stays low from acceptance until the response transfers
  one_in_flight: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_valid_i && req_ready_i) || (!req_ready_i && !(rsp_valid_i && rsp_ready_i))
      |=> !req_ready_i)
    else $error("req_ready_o high while a response is pending");

endmodule

/* tb/tb_read_only_cache.sv */
// ----------------------------------------------------------
// Testbench for the read-only cache
// Runs tb/roc_tests.txt, relative to the project root
// Memory model answers 3 cycles after taking a request
// Regions fixed at [0x1000,0x1100) and [0x2000,0x2080)
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "roc_defs.svh"

module tb_read_only_cache;
  import roc_pkg::*;

  localparam int MEM_LAT    = 3;
  localparam int WAIT_LIMIT = 200;

  logic  clk, rst_n;
  logic  enable, flush_valid, flush_ready;
  addr_t [`ROC_NR_RULES-1:0] start_addr, end_addr;
  logic  req_valid, req_ready, req_write;
  addr_t req_addr;
  data_t req_wdata;
  logic  rsp_valid;
  data_t rsp_data;
  logic  rsp_ready = 1'b1;
  logic  mem_req_valid, mem_req_write;
  addr_t mem_req_addr;
  data_t mem_req_wdata;
  logic  mem_req_ready = 1'b1;
  logic  mem_rsp_valid = 1'b0;
  data_t mem_rsp_data = '0;

  // Stimulus state shared with the checker
  logic       stall_en = 1'b0;
  int         test_id;
  data_t      exp_data;
  logic [1:0] exp_mode;
  int         tests_seen, errors_seen;
  bit         failed;

  // Behavioral memory
  data_t       mem_q [addr_t];
  int          lat_cnt = 0;
  data_t       pend_data = '0;
  logic [15:0] lfsr = 16'd72;

  // Untouched words read back as their address mixed with a constant
  function automatic data_t fill_word(input addr_t a);
    return a ^ 32'hC0DE_0000;
  endfunction

  // 16-bit Galois LFSR, one step per bit used
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ({1'b0, s[15:1]} ^ 16'hB400) : {1'b0, s[15:1]};
  endfunction

  tb_clock_gen i_clock_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  read_only_cache i_read_only_cache (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .enable_i        ( enable        ),
    .start_addr_i    ( start_addr    ),
    .end_addr_i      ( end_addr      ),
    .flush_valid_i   ( flush_valid   ),
    .flush_ready_o   ( flush_ready   ),
    .req_valid_i     ( req_valid     ),
    .req_addr_i      ( req_addr      ),
    .req_write_i     ( req_write     ),
    .req_wdata_i     ( req_wdata     ),
    .req_ready_o     ( req_ready     ),
    .rsp_valid_o     ( rsp_valid     ),
    .rsp_data_o      ( rsp_data      ),
    .rsp_ready_i     ( rsp_ready     ),
    .mem_req_valid_o ( mem_req_valid ),
    .mem_req_addr_o  ( mem_req_addr  ),
    .mem_req_write_o ( mem_req_write ),
    .mem_req_wdata_o ( mem_req_wdata ),
    .mem_req_ready_i ( mem_req_ready ),
    .mem_rsp_valid_i ( mem_rsp_valid ),
    .mem_rsp_data_i  ( mem_rsp_data  )
  );

  roc_checker i_checker (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .req_valid_i     ( req_valid     ),
    .req_ready_i     ( req_ready     ),
    .req_addr_i      ( req_addr      ),
    .req_write_i     ( req_write     ),
    .req_wdata_i     ( req_wdata     ),
    .rsp_valid_i     ( rsp_valid     ),
    .rsp_ready_i     ( rsp_ready     ),
    .rsp_data_i      ( rsp_data      ),
    .mem_req_valid_i ( mem_req_valid ),
    .mem_req_ready_i ( mem_req_ready ),
    .mem_req_addr_i  ( mem_req_addr  ),
    .mem_req_write_i ( mem_req_write ),
    .mem_req_wdata_i ( mem_req_wdata ),
    .flush_valid_i   ( flush_valid   ),
    .flush_ready_i   ( flush_ready   ),
    .test_id_i       ( test_id       ),
    .exp_data_i      ( exp_data      ),
    .exp_mode_i      ( exp_mode      ),
    .tests_o         ( tests_seen    ),
    .errors_o        ( errors_seen   )
  );

  bind read_only_cache roc_asserts i_asserts (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .req_valid_i     ( req_valid_i     ),
    .req_ready_i     ( req_ready_o     ),
    .rsp_valid_i     ( rsp_valid_o     ),
    .rsp_ready_i     ( rsp_ready_i     ),
    .rsp_data_i      ( rsp_data_o      ),
    .mem_req_valid_i ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_req_addr_i  ( mem_req_addr_o  ),
    .mem_req_write_i ( mem_req_write_o ),
    .mem_req_wdata_i ( mem_req_wdata_o )
  );

  // ----------------------------------------------------------
  // Memory model and stall generator
  // ----------------------------------------------------------
  always @(posedge clk) begin
    mem_rsp_valid <= 1'b0;
    if (!rst_n) begin
      lat_cnt <= 0;
    end else begin
      if (lat_cnt == 1) begin
        mem_rsp_valid <= 1'b1;
        mem_rsp_data  <= pend_data;
      end
      if (lat_cnt != 0) begin
        lat_cnt <= lat_cnt - 1;
      end
      if (mem_req_valid && mem_req_ready) begin
        lat_cnt <= MEM_LAT;
        if (mem_req_write) begin
          mem_q[mem_req_addr] = mem_req_wdata;
          pend_data <= '0;
        end else begin
          pend_data <= mem_q.exists(mem_req_addr) ? mem_q[mem_req_addr] :
                       fill_word(mem_req_addr);
        end
      end
    end
  end

  always @(posedge clk) begin
    if (stall_en) begin
      lfsr = lfsr_next(lfsr);
      mem_req_ready <= lfsr[0];
      lfsr = lfsr_next(lfsr);
      rsp_ready <= lfsr[0];
    end else begin
      mem_req_ready <= 1'b1;
      rsp_ready     <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  task automatic run_request(input logic is_write, input addr_t a, input data_t d);
    int cyc;
    bit done;
    req_valid <= 1'b1;
    req_addr  <= a;
    req_write <= is_write;
    req_wdata <= d;
    cyc  = 0;
    done = 1'b0;
    while (!done && cyc < WAIT_LIMIT) begin
      @(posedge clk);
      cyc++;
      done = req_ready;
    end
    req_valid <= 1'b0;
    if (!done) begin
      $display("timeout: request to address %h was never accepted", a);
      failed = 1'b1;
    end else begin
      cyc  = 0;
      done = 1'b0;
      while (!done && cyc < WAIT_LIMIT) begin
        @(posedge clk);
        cyc++;
        done = rsp_valid && rsp_ready;
      end
      if (!done) begin
        $display("timeout: no response came back for address %h", a);
        failed = 1'b1;
      end
    end
  endtask

  task automatic run_flush();
    int cyc;
    bit done;
    flush_valid <= 1'b1;
    cyc  = 0;
    done = 1'b0;
    while (!done && cyc < WAIT_LIMIT) begin
      @(posedge clk);
      cyc++;
      done = flush_ready;
    end
    flush_valid <= 1'b0;
    if (!done) begin
      $display("timeout: flush was never accepted");
      failed = 1'b1;
    end
  endtask

  initial begin
    int          fd, code, n, cyc;
    logic [8*128-1:0] hdr;
    logic [7:0]  op;
    addr_t       t_addr;
    data_t       t_data;
    int          t_en, t_mode, t_stall;
    n      = 0;
    failed = 1'b0;
    enable      <= 1'b0;
    flush_valid <= 1'b0;
    req_valid   <= 1'b0;
    req_addr    <= '0;
    req_write   <= 1'b0;
    req_wdata   <= '0;
    start_addr  <= {32'h0000_2000, 32'h0000_1000};
    end_addr    <= {32'h0000_2080, 32'h0000_1100};
    test_id     <= 0;
    exp_data    <= '0;
    exp_mode    <= 2'd0;
    cyc = 0;
    while (!rst_n && cyc < WAIT_LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    fd = $fopen("tb/roc_tests.txt", "r");
    if (!rst_n) begin
      $display("reset never released");
      failed = 1'b1;
    end else if (fd == 0) begin
      $display("could not open tb/roc_tests.txt");
      failed = 1'b1;
    end else begin
      // Two column-description lines lead the file
      code = $fgets(hdr, fd);
      code = $fgets(hdr, fd);
      code = $fscanf(fd, "%s %h %h %d %d %d", op, t_addr, t_data, t_en, t_mode, t_stall);
      while (code == 6 && !failed) begin
        @(posedge clk);
        n++;
        test_id  <= n;
        enable   <= t_en[0];
        stall_en <= t_stall[0];
        exp_mode <= t_mode[1:0];
        // Write acknowledgments carry zero data
        exp_data <= (op == "W") ? '0 : t_data;
        if (op == "F") begin
          run_flush();
        end else begin
          run_request(op == "W", t_addr, t_data);
        end
        code = $fscanf(fd, "%s %h %h %d %d %d", op, t_addr, t_data, t_en, t_mode, t_stall);
      end
      $fclose(fd);
    end
    repeat (2) @(posedge clk);
    if (tests_seen != n) begin
      $display("checker saw %0d finished tests but %0d were started", tests_seen, n);
    end
    $display("tests %0d, errors %0d", tests_seen, errors_seen);
    if (!failed && errors_seen == 0 && tests_seen == n && n > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tb/roc_tests.txt */
# op addr data en mode stall; op R read, W write, F flush; data is expected read or write data
# en drives enable_i; mode 1 hit without memory request, 2 memory request; stall 1 random stalls
R 00003000 C0DE3000 1 2 0
R 00003000 C0DE3000 1 2 0
R 00001004 C0DE1004 0 2 0
R 00001004 C0DE1004 0 2 0
R 00001008 C0DE1008 1 2 0
R 00001008 C0DE1008 1 1 0
W 00001008 12345678 1 2 0
R 00001008 C0DE1008 1 1 0
F 00000000 00000000 1 0 0
R 00001008 12345678 1 2 0
R 00001008 12345678 1 1 0
R 00001010 C0DE1010 1 2 0
R 00002010 C0DE2010 1 2 0
R 00001010 C0DE1010 1 2 0
R 00002010 C0DE2010 1 2 0
R 00002004 C0DE2004 1 2 1
R 00002004 C0DE2004 1 1 1
W 00003010 0BADF00D 1 2 1
R 00003010 0BADF00D 1 2 1
R 00001020 C0DE1020 1 2 1
W 00001020 11112222 1 2 1
R 00001020 C0DE1020 1 1 1
R 00000FFC C0DE0FFC 1 2 1
R 00001100 C0DE1100 1 2 1
R 00002080 C0DE2080 1 2 1
F 00000000 00000000 1 0 1
R 00001020 11112222 1 2 1
R 00002004 C0DE2004 1 2 1

/* compile.f */
+incdir+include
verilog/roc_pkg.sv
verilog/roc_mem_if.sv
verilog/roc_region_route.sv
verilog/roc_lookup.sv
verilog/roc_mem_arbiter.sv
verilog/read_only_cache.sv
tb/tb_clock_gen.sv
tb/roc_checker.sv
tb/roc_asserts.sv
tb/tb_read_only_cache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the read-only cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_read_only_cache \
  -Mdir obj_dir -o sim_roc || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_roc)
echo "$out"
echo "$out" | grep -qx "TEST OK" && exit 0 || exit 1
